//--- common/ahbPkg.sv
//////////////////////////////////////////////////
// AHB-Lite shared definitions
// Bus widths, HTRANS and HBURST encodings and the
// fixed attributes used by the multi-manager block
//////////////////////////////////////////////////

package ahbPkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Physical address width
  localparam int PaBits = 32;
  // Core data width
  localparam int Xlen = 32;
  // Bus data width matches the core
  localparam int AhbW = Xlen;
  // One strobe bit per byte lane
  localparam int StrbBits = Xlen / 8;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // HTRANS, BUSY is never issued here
  localparam logic [1:0] HtransIdle   = 2'b00;
  localparam logic [1:0] HtransNonseq = 2'b10;
  localparam logic [1:0] HtransSeq    = 2'b11;

  // HBURST, wrapping bursts are not used
  localparam logic [2:0] BurstSingle = 3'b000;
  localparam logic [2:0] BurstIncr   = 3'b001;
  localparam logic [2:0] BurstIncr4  = 3'b011;
  localparam logic [2:0] BurstIncr8  = 3'b101;
  localparam logic [2:0] BurstIncr16 = 3'b111;

  // Instruction fetches are always one word
  localparam logic [2:0] InstrSize = 3'b010;

  // Data access, privileged, not bufferable or cacheable
  localparam logic [3:0] HprotConst = 4'b0011;

endpackage

//--- common/ahbMgrIf.sv
//////////////////////////////////////////////////
// AHB-Lite manager request bundle
// One manager's address phase after the input
// stage, plus the ready returned to it
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface ahbMgrIf;

  import ahbPkg::*;

  // Address phase fields
  logic [PaBits-1:0] haddr;
  logic [1:0]        htrans;
  logic [2:0]        hburst;
  logic [2:0]        hsize;
  logic              hwrite;

  // Ready back toward the manager
  logic              hready;

  //////////////////////////////////////////////////
  // Views
  //////////////////////////////////////////////////

  // Input stage presents the live or saved request
  modport stage (
    output haddr, htrans, hburst, hsize, hwrite,
    input  hready
  );

  // Arbiter picks a winner and gates ready
  modport arb (
    input  haddr, htrans, hburst, hsize, hwrite,
    output hready
  );

  // Burst observer only needs transfer kind and length
  modport tracker (
    input htrans, hburst
  );

endinterface

//--- multimanager/managerInputStage.sv
//////////////////////////////////////////////////
// Manager input stage
// Holds a copy of one manager's address phase when
// it loses arbitration and replays it on restore
//////////////////////////////////////////////////

`timescale 1ns/1ps

module managerInputStage (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      save,
  input  logic                      restore,
  input  logic [ahbPkg::PaBits-1:0] haddrIn,
  input  logic [1:0]                htransIn,
  input  logic [2:0]                hburstIn,
  input  logic [2:0]                hsizeIn,
  input  logic                      hwriteIn,
  ahbMgrIf.stage                    req
);

  import ahbPkg::*;

  logic [PaBits-1:0] haddrSave;
  logic [1:0]        htransSave;
  logic [2:0]        hburstSave;
  logic [2:0]        hsizeSave;
  logic              hwriteSave;

  // Saved transfer kind, cleared so a stray restore replays idle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      htransSave <= HtransIdle;
    end else if (save) begin
      htransSave <= htransIn;
    end
  end

  // Payload of the saved request
  always_ff @(posedge clk) begin
    if (save) begin
      haddrSave  <= haddrIn;
      hburstSave <= hburstIn;
      hsizeSave  <= hsizeIn;
      hwriteSave <= hwriteIn;
    end
  end

  //////////////////////////////////////////////////
  // Restore mux
  //////////////////////////////////////////////////

  // Live request unless the arbiter asks for the saved one
  always_comb begin
    if (restore) begin
      req.haddr  = haddrSave;
      req.htrans = htransSave;
      req.hburst = hburstSave;
      req.hsize  = hsizeSave;
      req.hwrite = hwriteSave;
    end else begin
      req.haddr  = haddrIn;
      req.htrans = htransIn;
      req.hburst = hburstIn;
      req.hsize  = hsizeIn;
      req.hwrite = hwriteIn;
    end
  end

endmodule

//--- multimanager/burstTracker.sv
//////////////////////////////////////////////////
// Burst tracker
// Counts the beats of the granted transfer and
// flags the data phase of its final beat
//////////////////////////////////////////////////

`timescale 1ns/1ps

module burstTracker (
  input  logic       clk,
  input  logic       arstN,
  input  logic [1:0] htrans,
  input  logic [2:0] hburst,
  input  logic       hready,
  input  logic       busy,
  output logic       lastBeat
);

  import ahbPkg::*;

  // Burst type of the transfer now on the bus
  logic [2:0] hburstD;
  // Beats granted, and the same count one data phase later
  logic [3:0] beatCnt;
  logic [3:0] beatCntD;
  // Index of the final beat
  logic [3:0] threshold;
  logic       cntEn;

  //////////////////////////////////////////////////
  // Burst capture
  //////////////////////////////////////////////////

  // A NONSEQ address phase starts a new transfer
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      hburstD <= BurstSingle;
    end else if (htrans == HtransNonseq) begin
      hburstD <= hburst;
    end
  end

  // Undefined-length INCR ends after one beat
  always_comb begin
    case (hburstD)
      BurstSingle: threshold = 4'd0;
      BurstIncr:   threshold = 4'd0;
      BurstIncr4:  threshold = 4'd3;
      BurstIncr8:  threshold = 4'd7;
      BurstIncr16: threshold = 4'd15;
      default:     threshold = 4'd0;
    endcase
  end

  //////////////////////////////////////////////////
  // Beat counters
  //////////////////////////////////////////////////

  // Advance only on an accepted beat while the arbiter is busy
  assign cntEn = busy & hready;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      beatCnt  <= '0;
      beatCntD <= '0;
    end else if (!busy) begin
      // Leaving arbitration, start fresh for the next collision
      beatCnt  <= '0;
      beatCntD <= '0;
    end else if (cntEn) begin
      beatCnt  <= beatCnt + 4'd1;
      beatCntD <= beatCnt;
    end
  end

  // Delayed count lines up with the data phase of the final beat
  assign lastBeat = (beatCntD == threshold);

endmodule

//--- multimanager/ahbArbiter.sv
//////////////////////////////////////////////////
// AHB-Lite arbiter for two managers
// Fixed LSU priority; a colliding IFU request is
// saved, its ready held low, and replayed after
// the last beat of the LSU transfer
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ahbArbiter (
  input  logic                      clk,
  input  logic                      arstN,
  ahbMgrIf.arb                      ifu,
  ahbMgrIf.arb                      lsu,
  input  logic                      hready,
  input  logic                      lastBeat,
  output logic                      ifuSave,
  output logic                      ifuRestore,
  output logic                      busy,
  output logic [ahbPkg::PaBits-1:0] haddr,
  output logic [1:0]                htrans,
  output logic [2:0]                hburst,
  output logic [2:0]                hsize,
  output logic                      hwrite
);

  import ahbPkg::*;

  typedef enum logic {Idle, Arbitrate} arbStateT;

  arbStateT currState;
  arbStateT nextState;

  logic ifuReq;
  logic lsuReq;
  logic ifuActive;
  logic lsuActive;
  logic both;
  logic ifuDis;
  logic ifuSel;
  logic lsuSel;

  //////////////////////////////////////////////////
  // Requests and ready
  //////////////////////////////////////////////////

  assign ifuReq = (ifu.htrans != HtransIdle);
  assign lsuReq = (lsu.htrans != HtransIdle);

  // IFU stalls for the whole replay window
  assign ifuDis    = (currState == Arbitrate);
  assign ifu.hready = hready & ~ifuDis;
  // LSU always wins, so its ready is never gated
  assign lsu.hready = hready;

  assign ifuActive = ifuReq & ifu.hready;
  assign lsuActive = lsuReq & lsu.hready;
  assign both      = ifuActive & lsuActive;

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      currState <= Idle;
    end else begin
      currState <= nextState;
    end
  end

  // Stay busy until the final LSU beat completes
  always_comb begin
    case (currState)
      Idle:      nextState = both ? Arbitrate : Idle;
      Arbitrate: nextState = (hready & lastBeat) ? Idle : Arbitrate;
      default:   nextState = Idle;
    endcase
  end

  assign busy = (nextState == Arbitrate);

  // Capture the loser on the collision cycle, replay it afterwards
  assign ifuSave    = (currState == Idle) & both;
  assign ifuRestore = (currState == Arbitrate);

  //////////////////////////////////////////////////
  // Output mux
  //////////////////////////////////////////////////

  // Selection looks ahead so the replay starts in the exit cycle
  assign lsuSel = busy ? 1'b1 : lsuReq;
  assign ifuSel = busy ? 1'b0 : ifuReq;

  always_comb begin
    if (lsuSel) begin
      haddr  = lsu.haddr;
      htrans = lsu.htrans;
      hburst = lsu.hburst;
      hsize  = lsu.hsize;
      hwrite = lsu.hwrite;
    end else if (ifuSel) begin
      haddr  = ifu.haddr;
      htrans = ifu.htrans;
      hburst = ifu.hburst;
      // Fetches are word reads regardless of the stage fields
      hsize  = InstrSize;
      hwrite = 1'b0;
    end else begin
      // Nobody asking, park the bus idle
      haddr  = '0;
      htrans = HtransIdle;
      hburst = '0;
      hsize  = '0;
      hwrite = 1'b0;
    end
  end

endmodule

//--- multimanager/ahbMultiManager.sv
//////////////////////////////////////////////////
// AHB-Lite multi-manager
// Merges instruction fetch and load/store traffic
// onto one AHB-Lite manager port
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ahbMultiManager (
  input  logic                        clk,
  input  logic                        arstN,
  // Instruction fetch manager
  input  logic [ahbPkg::PaBits-1:0]   ifuHaddr,
  input  logic [1:0]                  ifuHtrans,
  input  logic [2:0]                  ifuHburst,
  output logic                        ifuHready,
  // Load/store manager
  input  logic [ahbPkg::PaBits-1:0]   lsuHaddr,
  input  logic [ahbPkg::Xlen-1:0]     lsuHwdata,
  input  logic [ahbPkg::StrbBits-1:0] lsuHwstrb,
  input  logic [2:0]                  lsuHsize,
  input  logic [2:0]                  lsuHburst,
  input  logic [1:0]                  lsuHtrans,
  input  logic                        lsuHwrite,
  output logic                        lsuHready,
  // AHB-Lite bus
  input  logic                        HREADY,
  // No error handling, response is ignored
  input  logic                        HRESP,
  output logic                        HCLK,
  output logic                        HRESETn,
  output logic [ahbPkg::PaBits-1:0]   HADDR,
  output logic [ahbPkg::AhbW-1:0]     HWDATA,
  output logic [ahbPkg::StrbBits-1:0] HWSTRB,
  output logic                        HWRITE,
  output logic [2:0]                  HSIZE,
  output logic [2:0]                  HBURST,
  output logic [3:0]                  HPROT,
  output logic [1:0]                  HTRANS,
  output logic                        HMASTLOCK
);

  import ahbPkg::*;

  logic ifuSave;
  logic ifuRestore;
  logic busy;
  logic lastBeat;

  ahbMgrIf ifuIf ();
  ahbMgrIf lsuIf ();

  //////////////////////////////////////////////////
  // Input stages
  //////////////////////////////////////////////////

  // IFU has no size or write inputs, fetches are word reads
  managerInputStage ifuStage (
    .clk      (clk),
    .arstN    (arstN),
    .save     (ifuSave),
    .restore  (ifuRestore),
    .haddrIn  (ifuHaddr),
    .htransIn (ifuHtrans),
    .hburstIn (ifuHburst),
    .hsizeIn  (InstrSize),
    .hwriteIn (1'b0),
    .req      (ifuIf)
  );

  // LSU never loses, so it is never saved or restored
  managerInputStage lsuStage (
    .clk      (clk),
    .arstN    (arstN),
    .save     (1'b0),
    .restore  (1'b0),
    .haddrIn  (lsuHaddr),
    .htransIn (lsuHtrans),
    .hburstIn (lsuHburst),
    .hsizeIn  (lsuHsize),
    .hwriteIn (lsuHwrite),
    .req      (lsuIf)
  );

  assign ifuHready = ifuIf.hready;
  assign lsuHready = lsuIf.hready;

  //////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////

  ahbArbiter arbiter (
    .clk        (clk),
    .arstN      (arstN),
    .ifu        (ifuIf),
    .lsu        (lsuIf),
    .hready     (HREADY),
    .lastBeat   (lastBeat),
    .ifuSave    (ifuSave),
    .ifuRestore (ifuRestore),
    .busy       (busy),
    .haddr      (HADDR),
    .htrans     (HTRANS),
    .hburst     (HBURST),
    .hsize      (HSIZE),
    .hwrite     (HWRITE)
  );

  // Watches the bus itself to find the end of the winning burst
  burstTracker tracker (
    .clk      (clk),
    .arstN    (arstN),
    .htrans   (HTRANS),
    .hburst   (HBURST),
    .hready   (HREADY),
    .busy     (busy),
    .lastBeat (lastBeat)
  );

  // Bus clock and reset follow the core
  assign HCLK    = clk;
  assign HRESETn = arstN;

  // Write data only ever comes from the LSU
  assign HWDATA = lsuHwdata;
  assign HWSTRB = lsuHwstrb;

  assign HPROT     = HprotConst;
  assign HMASTLOCK = 1'b0;

endmodule

//--- testbench/tbClock.sv
//////////////////////////////////////////////////
// Testbench clock and reset
// 20 ns clock, reset held low for five cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Release on a falling edge, like every other input
  initial begin
    arstN = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
  end

endmodule

//--- testbench/ahbMultiManager_asserts.sv
//////////////////////////////////////////////////
// Bus rule checks for the multi-manager
// Bound onto the top level, watches its ports
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ahbMultiManager_asserts (
  input logic       clk,
  input logic       arstN,
  input logic       HMASTLOCK,
  input logic       HREADY,
  input logic       HWRITE,
  input logic [1:0] HTRANS,
  input logic [1:0] lsuHtrans,
  input logic       ifuHready,
  input logic       lsuHready
);

  import ahbPkg::*;

  // Locked transfers are never issued
  noLock: assert property (@(posedge clk) disable iff (!arstN) !HMASTLOCK)
    else $error("HMASTLOCK went high");

  // IFU cannot run ahead of a stalled bus
  ifuStall: assert property (@(posedge clk) disable iff (!arstN)
    (!lsuHready && !HREADY) |-> !ifuHready)
    else $error("ifuHready high while the bus is stalled");

  // With the LSU idle, any transfer on the bus is a fetch
  fetchRead: assert property (@(posedge clk) disable iff (!arstN)
    (lsuHtrans == HtransIdle && HTRANS != HtransIdle) |-> !HWRITE)
    else $error("instruction fetch shown as a write");

  // Address phase held through wait states
  // An idle bus may still start a transfer
  holdTrans: assert property (@(posedge clk) disable iff (!arstN)
    (!HREADY && HTRANS != HtransIdle) |=> $stable(HTRANS))
    else $error("HTRANS changed during a wait state");

endmodule

bind ahbMultiManager ahbMultiManager_asserts asserts (
  .clk       (clk),
  .arstN     (arstN),
  .HMASTLOCK (HMASTLOCK),
  .HREADY    (HREADY),
  .HWRITE    (HWRITE),
  .HTRANS    (HTRANS),
  .lsuHtrans (lsuHtrans),
  .ifuHready (ifuHready),
  .lsuHready (lsuHready)
);

//--- testbench/tbAhbMultiManager.sv
//////////////////////////////////////////////////
// Testbench for the AHB-Lite multi-manager
// Table of IFU/LSU scenarios, random wait states,
// bus monitor and grant order checks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tbAhbMultiManager;

  import ahbPkg::*;

  typedef struct {
    logic [31:0] ifuAddr;
    logic [2:0]  ifuBurst;
    bit          ifuOn;
    logic [31:0] lsuAddr;
    logic [2:0]  lsuSize;
    logic [2:0]  lsuBurst;
    bit          lsuWrite;
    logic [31:0] lsuData;
    logic [3:0]  lsuStrb;
    bit          lsuOn;
    logic [31:0] maxWait;
    // 0 nothing, 1 IFU, 2 LSU, 3 LSU then IFU
    int          order;
  } rowT;

  localparam int NumRows   = 8;
  localparam int MaxWait   = 3;
  localparam int TimeoutNs = NumRows * 40 * 20 * (MaxWait + 1) + 200;

  logic clk;
  logic arstN;
  logic [31:0] ifuHaddr;
  logic [1:0]  ifuHtrans;
  logic [2:0]  ifuHburst;
  logic        ifuHready;
  logic [31:0] lsuHaddr;
  logic [31:0] lsuHwdata;
  logic [3:0]  lsuHwstrb;
  logic [2:0]  lsuHsize;
  logic [2:0]  lsuHburst;
  logic [1:0]  lsuHtrans;
  logic        lsuHwrite;
  logic        lsuHready;
  logic        HREADY;
  logic        HRESP;
  logic        HCLK;
  logic        HRESETn;
  logic [31:0] HADDR;
  logic [31:0] HWDATA;
  logic [3:0]  HWSTRB;
  logic        HWRITE;
  logic [2:0]  HSIZE;
  logic [2:0]  HBURST;
  logic [3:0]  HPROT;
  logic [1:0]  HTRANS;
  logic        HMASTLOCK;

  rowT         rows [NumRows];
  rowT         curRow;
  logic [31:0] rng;
  logic [31:0] seen [$];
  logic        phaseStart;
  int          waitLeft;
  int          ifuStalls;
  int          checks;
  int          errors;

  tbClock clkGen (.clk(clk), .arstN(arstN));

  ahbMultiManager uut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Beat count of a fixed-length burst, INCR ends after one beat
  function automatic int burstBeats(input logic [2:0] burst);
    case (burst)
      BurstIncr4:  return 4;
      BurstIncr8:  return 8;
      BurstIncr16: return 16;
      default:     return 1;
    endcase
  endfunction

  function automatic rowT makeRow(input logic [31:0] ia, input bit io, input logic [31:0] la,
                                  input logic [2:0] ls, input logic [2:0] lb, input bit lw,
                                  input logic [31:0] ld, input logic [3:0] st, input bit lo,
                                  input logic [31:0] mw, input int ord);
    rowT r;
    r.ifuAddr  = ia;
    r.ifuBurst = BurstSingle;
    r.ifuOn    = io;
    r.lsuAddr  = la;
    r.lsuSize  = ls;
    r.lsuBurst = lb;
    r.lsuWrite = lw;
    r.lsuData  = ld;
    r.lsuStrb  = st;
    r.lsuOn    = lo;
    r.maxWait  = mw;
    r.order    = ord;
    return r;
  endfunction

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Subordinate model and monitor
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    phaseStart <= HREADY && (HTRANS != HtransIdle);
  end

  // Fresh random wait count at the start of every data phase
  initial begin
    rng      = 32'h6561e390;
    HREADY   = 1'b1;
    waitLeft = 0;
    forever begin
      @(negedge clk);
      if (phaseStart) begin
        rng      = xorshift(rng);
        waitLeft = int'(rng % (curRow.maxWait + 1));
      end
      HREADY = (waitLeft == 0);
      if (waitLeft > 0) waitLeft--;
    end
  end

  // Bus clock and reset mirror the core ones just after each edge
  always @(clk) begin
    #1;
    compare(32'(HCLK), 32'(clk), "HCLK");
    compare(32'(HRESETn), 32'(arstN), "HRESETn");
  end

  // Every accepted address phase in bus order
  always @(posedge clk) begin
    // Idle rows and reset have no saved fetch to replay
    if (ifuHtrans == HtransIdle && lsuHtrans == HtransIdle &&
        (!arstN || curRow.order == 0))
      compare(32'(HTRANS), 32'(HtransIdle), "HTRANS with no request");
    if (arstN) begin
      compare(32'(HPROT), 32'(HprotConst), "HPROT");
      compare(32'(HMASTLOCK), 32'd0, "HMASTLOCK");
      compare(32'(lsuHready), 32'(HREADY), "lsuHready follows HREADY");
      if (curRow.order == 1)
        compare(32'(ifuHready), 32'(HREADY), "ifuHready follows HREADY");
      // Fetch held back by the arbiter while the bus moves
      if (HREADY && !ifuHready)
        ifuStalls++;
      // LSU addresses sit above 0x8000_0000
      if (HREADY && HTRANS != HtransIdle && HADDR[31]) begin
        seen.push_back(HADDR);
        compare(32'(HSIZE), 32'(curRow.lsuSize), "LSU HSIZE");
        compare(32'(HBURST), 32'(curRow.lsuBurst), "LSU HBURST");
        compare(32'(HWRITE), 32'(curRow.lsuWrite), "LSU HWRITE");
        compare(HWDATA, curRow.lsuData, "HWDATA");
        compare(32'(HWSTRB), 32'(curRow.lsuStrb), "HWSTRB");
      end else if (HREADY && HTRANS != HtransIdle) begin
        seen.push_back(HADDR);
        compare(32'(HSIZE), 32'(InstrSize), "IFU HSIZE");
        compare(32'(HBURST), 32'(curRow.ifuBurst), "IFU HBURST");
        compare(32'(HWRITE), 32'd0, "IFU HWRITE");
      end
    end
  end

  //////////////////////////////////////////////////
  // Scenario runner
  //////////////////////////////////////////////////

  task automatic runRow(input int idx);
    int          ifuLeft;
    int          lsuLeft;
    int          errBefore;
    bit          ifuTook;
    bit          lsuTook;
    logic [31:0] expAddr [$];
    curRow    = rows[idx];
    errBefore = errors;
    ifuLeft   = curRow.ifuOn ? 1 : 0;
    lsuLeft   = curRow.lsuOn ? burstBeats(curRow.lsuBurst) : 0;
    ifuStalls = 0;
    seen.delete();
    @(negedge clk);
    if (curRow.ifuOn) begin
      ifuHaddr  = curRow.ifuAddr;
      ifuHburst = curRow.ifuBurst;
      ifuHtrans = HtransNonseq;
    end
    if (curRow.lsuOn) begin
      lsuHaddr  = curRow.lsuAddr;
      lsuHsize  = curRow.lsuSize;
      lsuHburst = curRow.lsuBurst;
      lsuHwrite = curRow.lsuWrite;
      lsuHwdata = curRow.lsuData;
      lsuHwstrb = curRow.lsuStrb;
      lsuHtrans = HtransNonseq;
    end
    // Each manager moves on only when its own ready is seen high
    while (ifuLeft > 0 || lsuLeft > 0) begin
      @(posedge clk);
      ifuTook = (ifuHtrans != HtransIdle) && ifuHready;
      lsuTook = (lsuHtrans != HtransIdle) && lsuHready;
      @(negedge clk);
      if (ifuTook) begin
        ifuLeft--;
        ifuHtrans = HtransIdle;
      end
      if (lsuTook) begin
        lsuLeft--;
        if (lsuLeft == 0) begin
          lsuHtrans = HtransIdle;
        end else begin
          lsuHaddr  = lsuHaddr + 32'd4;
          lsuHtrans = HtransSeq;
        end
      end
    end
    // Let the last data phase finish
    @(posedge clk);
    while (!HREADY) @(posedge clk);
    repeat (2) @(posedge clk);
    // LSU beats first, the fetch after them
    if (curRow.order >= 2)
      for (int i = 0; i < burstBeats(curRow.lsuBurst); i++)
        expAddr.push_back(curRow.lsuAddr + 32'(4 * i));
    if (curRow.order == 1 || curRow.order == 3)
      expAddr.push_back(curRow.ifuAddr);
    compare(32'(seen.size()), 32'(expAddr.size()), "accepted phase count");
    for (int i = 0; i < expAddr.size() && i < seen.size(); i++)
      compare(seen[i], expAddr[i], $sformatf("grant %0d address", i));
    // Only a collision holds the fetch back
    compare(32'(ifuStalls > 0), 32'(curRow.order == 3), "IFU stalled only on collision");
    if (errors == errBefore)
      $display("row %0d order %0d: ok", idx, curRow.order);
    else
      $display("row %0d order %0d: bad, %0d errors", idx, curRow.order, errors - errBefore);
  endtask

  // Run length is bounded by the table size and the worst wait
  initial begin
    #(TimeoutNs);
    $display("Timeout: the scenarios did not finish in time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    checks    = 0;
    errors    = 0;
    ifuStalls = 0;
    ifuHaddr  = '0;
    ifuHtrans = HtransIdle;
    ifuHburst = BurstSingle;
    lsuHaddr  = '0;
    lsuHwdata = '0;
    lsuHwstrb = '0;
    lsuHsize  = '0;
    lsuHburst = BurstSingle;
    lsuHtrans = HtransIdle;
    lsuHwrite = 1'b0;
    HRESP     = 1'b0;
    rows[0] = makeRow(32'h0, 0, 32'h0, 3'd2, BurstSingle, 0, 32'h0, 4'h0, 0, 1, 0);
    rows[1] = makeRow(32'h100, 1, 32'h0, 3'd2, BurstSingle, 0, 32'h0, 4'h0, 0, 1, 1);
    rows[2] = makeRow(32'h0, 0, 32'h8000_0010, 3'd0, BurstSingle, 1, 32'h0000_00a5, 4'h1, 1,
                      2, 2);
    rows[3] = makeRow(32'h200, 1, 32'h8000_0020, 3'd2, BurstSingle, 0, 32'h0, 4'hf, 1, 0, 3);
    rows[4] = makeRow(32'h300, 1, 32'h8000_0100, 3'd2, BurstIncr4, 1, 32'hcafe_f00d, 4'hf, 1,
                      MaxWait, 3);
    rows[5] = makeRow(32'h400, 1, 32'h8000_0200, 3'd2, BurstIncr8, 0, 32'h0, 4'hf, 1,
                      MaxWait, 3);
    rows[6] = rows[4];
    rows[7] = rows[0];
    curRow = rows[0];
    wait (arstN === 1'b1);
    for (int i = 0; i < NumRows; i++)
      runRow(i);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb.f
common/ahbPkg.sv
common/ahbMgrIf.sv
multimanager/managerInputStage.sv
multimanager/burstTracker.sv
multimanager/ahbArbiter.sv
multimanager/ahbMultiManager.sv
testbench/tbClock.sv
testbench/ahbMultiManager_asserts.sv
testbench/tbAhbMultiManager.sv

//--- Makefile
TOP := tbAhbMultiManager

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
